/* flist.f */
rtl/imuldiv_pkg.sv
rtl/imuldiv_mul_ctrl.sv
rtl/imuldiv_mul_dpath.sv
rtl/imuldiv_div_iterative.sv
rtl/imuldiv_unit.sv
verification/tb_imuldiv_unit.sv

/* rtl/imuldiv_div_iterative.sv */
// restoring divider with one quotient bit per cycle, signed or unsigned
// result is {remainder, quotient}; divide by zero gives all-ones quotient

`timescale 1ns/1ps

module imuldiv_div_iterative import imuldiv_pkg::*; (
  input  logic              clk,
  input  logic              reset,

  input  logic              req_val,
  output logic              req_rdy,
  input  logic              req_signed,
  input  logic [xlen-1:0]   req_a,
  input  logic [xlen-1:0]   req_b,

  output logic              resp_val,
  input  logic              resp_rdy,
  output logic [2*xlen-1:0] resp_result
);

  iter_state_e state;
  logic [count_w-1:0] count;

  logic              accept;
  logic              a_neg;
  logic              b_neg;
  logic [xlen-1:0]   abs_a;
  logic [xlen-1:0]   abs_b;

  // remainder in the upper half and dividend/quotient bits in the lower half
  logic [2*xlen-1:0] rq;
  logic [xlen-1:0]   divisor;
  logic              neg_q;
  logic              neg_r;

  logic [xlen+1:0]   diff;
  logic [xlen-1:0]   quo;
  logic [xlen-1:0]   rem;

  assign accept = req_val && req_rdy;

  // unsigned requests take the operands as they are
  assign a_neg = req_signed && req_a[xlen-1];
  assign b_neg = req_signed && req_b[xlen-1];
  assign abs_a = a_neg ? (~req_a + 1'b1) : req_a;
  assign abs_b = b_neg ? (~req_b + 1'b1) : req_b;

  // ----------------------------------------
  // control
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_val) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (count == count_w'(iter_count - 1)) begin
            state <= st_done;
          end
          count <= count + 1'b1;
        end
        st_done: begin
          if (resp_rdy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  // shifted remainder can need 33 bits and the top bit of diff is the borrow
  assign diff = {1'b0, rq[2*xlen-1:xlen-1]} - {2'b00, divisor};

  always_ff @(posedge clk) begin
    if (accept) begin
      rq      <= {{xlen{1'b0}}, abs_a};
      divisor <= abs_b;
      neg_q   <= a_neg ^ b_neg;
      neg_r   <= a_neg;
    end else if (state == st_calc) begin
      if (!diff[xlen+1]) begin
        // divisor fits so keep the difference and set the quotient bit
        rq <= {diff[xlen-1:0], rq[xlen-2:0], 1'b1};
      end else begin
        // restore by a plain shift with a zero quotient bit
        rq <= {rq[2*xlen-2:0], 1'b0};
      end
    end
  end

  // a zero divisor keeps the all-ones quotient from the loop
  assign quo = (neg_q && (divisor != '0)) ? (~rq[xlen-1:0] + 1'b1) : rq[xlen-1:0];
  // remainder follows the dividend sign
  assign rem = neg_r ? (~rq[2*xlen-1:xlen] + 1'b1) : rq[2*xlen-1:xlen];

  assign resp_result = {rem, quo};

  // counter only leaves zero while stepping and wraps back after the last step
  assert property (@(posedge clk) disable iff (reset)
    (state != st_calc) |-> (count == '0));

endmodule

/* rtl/imuldiv_mul_ctrl.sv */
// multiplier sequencer that runs exactly iter_count steps per request
// response is held in st_done until the consumer takes it

`timescale 1ns/1ps

module imuldiv_mul_ctrl import imuldiv_pkg::*; (
  input  logic clk,
  input  logic reset,

  input  logic req_val,
  output logic req_rdy,

  output logic resp_val,
  input  logic resp_rdy,

  output logic load,
  output logic step
);

  iter_state_e state;
  logic [count_w-1:0] count;

  // ----------------------------------------
  // state and step counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_val) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          // last step leaves the product ready in the accumulator
          if (count == count_w'(iter_count - 1)) begin
            state <= st_done;
          end
          count <= count + 1'b1;
        end
        st_done: begin
          if (resp_rdy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------
  // handshake and datapath controls
  // ----------------------------------------

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  // operands captured on the accepting edge
  assign load     = req_val && req_rdy;
  assign step     = (state == st_calc);

  // counter wraps back to zero on the last step, so every run starts from zero
  assert property (@(posedge clk) disable iff (reset)
    !step |-> (count == '0));

  // offered response is not withdrawn before the consumer takes it
  assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val);

endmodule

/* rtl/imuldiv_mul_dpath.sv */
// shift-and-add multiplier datapath, signed operands only
// magnitudes are multiplied and the sign is applied to the 64-bit product

`timescale 1ns/1ps

module imuldiv_mul_dpath import imuldiv_pkg::*; (
  input  logic                clk,
  input  logic                reset,

  input  logic [xlen-1:0]     req_a,
  input  logic [xlen-1:0]     req_b,

  input  logic                load,
  input  logic                step,

  output logic [2*xlen-1:0]   resp_result
);

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  logic            sign_a;
  logic            sign_b;
  logic [xlen-1:0] abs_a;
  logic [xlen-1:0] abs_b;

  assign sign_a = req_a[xlen-1];
  assign sign_b = req_b[xlen-1];
  // 0x80000000 maps to 2^31, which is still right as unsigned
  assign abs_a  = sign_a ? (~req_a + 1'b1) : req_a;
  assign abs_b  = sign_b ? (~req_b + 1'b1) : req_b;

  // ----------------------------------------
  // iteration registers
  // ----------------------------------------

  logic [2*xlen-1:0] mcand;
  logic [xlen-1:0]   mplier;
  logic [2*xlen-1:0] acc;
  logic              neg;

  // operand registers only change under load or step
  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{xlen{1'b0}}, abs_a};
      mplier <= abs_b;
    end else if (step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
      neg <= 1'b0;
    end else if (load) begin
      acc <= '0;
      neg <= sign_a ^ sign_b;
    end else if (step) begin
      // add in the current partial product when the multiplier bit is set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
    end
  end

  // ----------------------------------------
  // sign fix-up
  // ----------------------------------------

  assign resp_result = neg ? (~acc + 1'b1) : acc;

endmodule

/* rtl/imuldiv_pkg.sv */
// shared widths and encodings for the multiply/divide unit
// operand width is fixed at 32 bits and every operation takes 32 steps

package imuldiv_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------

  // operand width, results are twice this
  localparam int unsigned xlen = 32;

  // one step per operand bit
  localparam int unsigned iter_count = 32;

  // step counter covers 0 .. iter_count-1
  localparam int unsigned count_w = 5;

  // ----------------------------------------
  // encodings
  // ----------------------------------------

  // request function code
  // code 3 is unused and is handled as a multiply
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } imuldiv_fn_e;

  // sequencing state shared by the multiplier and the divider
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } iter_state_e;

endpackage

/* rtl/imuldiv_unit.sv */
// multiply/divide unit top with one operation in flight at a time
// function code 3 is treated as a signed multiply

`timescale 1ns/1ps

module imuldiv_unit import imuldiv_pkg::*; (
  input  logic              clk,
  input  logic              reset,

  input  logic              req_val,
  output logic              req_rdy,
  input  imuldiv_fn_e       req_fn,
  input  logic [xlen-1:0]   req_a,
  input  logic [xlen-1:0]   req_b,

  output logic              resp_val,
  input  logic              resp_rdy,
  output logic [2*xlen-1:0] resp_result
);

  // which sub-unit holds the operation in flight
  typedef enum logic [1:0] {
    own_none = 2'd0,
    own_mul  = 2'd1,
    own_div  = 2'd2
  } owner_e;

  owner_e owner;

  logic              is_div;
  logic              mul_req_val, mul_req_rdy, mul_resp_val, mul_resp_rdy;
  logic              div_req_val, div_req_rdy, div_resp_val, div_resp_rdy;
  logic              load, step;
  logic [2*xlen-1:0] mul_result;
  logic [2*xlen-1:0] div_result;

  // ----------------------------------------
  // dispatch
  // ----------------------------------------

  assign is_div      = (req_fn == fn_div) || (req_fn == fn_divu);
  assign req_rdy     = (owner == own_none);
  assign mul_req_val = req_val && req_rdy && !is_div;
  assign div_req_val = req_val && req_rdy && is_div;

  always_ff @(posedge clk) begin
    if (reset) begin
      owner <= own_none;
    end else begin
      case (owner)
        own_none: begin
          if (mul_req_val && mul_req_rdy) owner <= own_mul;
          else if (div_req_val && div_req_rdy) owner <= own_div;
        end
        own_mul: if (mul_resp_val && mul_resp_rdy) owner <= own_none;
        own_div: if (div_resp_val && div_resp_rdy) owner <= own_none;
        default: owner <= own_none;
      endcase
    end
  end

  // ----------------------------------------
  // response steering
  // ----------------------------------------

  assign mul_resp_rdy = resp_rdy && (owner == own_mul);
  assign div_resp_rdy = resp_rdy && (owner == own_div);
  assign resp_val     = (owner == own_mul) ? mul_resp_val :
                        (owner == own_div) ? div_resp_val : 1'b0;
  assign resp_result  = (owner == own_div) ? div_result : mul_result;

  imuldiv_mul_ctrl mul_ctrl (
    .clk (clk), .reset (reset),
    .req_val (mul_req_val), .req_rdy (mul_req_rdy),
    .resp_val (mul_resp_val), .resp_rdy (mul_resp_rdy),
    .load (load), .step (step)
  );

  imuldiv_mul_dpath mul_dpath (
    .clk (clk), .reset (reset),
    .req_a (req_a), .req_b (req_b),
    .load (load), .step (step),
    .resp_result (mul_result)
  );

  imuldiv_div_iterative div (
    .clk (clk), .reset (reset),
    .req_val (div_req_val), .req_rdy (div_req_rdy),
    .req_signed (req_fn == fn_div),
    .req_a (req_a), .req_b (req_b),
    .resp_val (div_resp_val), .resp_rdy (div_resp_rdy),
    .resp_result (div_result)
  );

  // a dispatched sub-unit must be idle when the top hands it a request
  assert property (@(posedge clk) disable iff (reset)
    mul_req_val |-> mul_req_rdy);

  assert property (@(posedge clk) disable iff (reset)
    div_req_val |-> div_req_rdy);

  assert property (@(posedge clk) disable iff (reset)
    !(mul_resp_val && div_resp_val));

endmodule

/* run.sh */
#!/bin/sh
# build with Verilator, run, and decide pass or fail from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_imuldiv_unit \
  -o tb_imuldiv_unit > build.log 2>&1 &&
  ./obj_dir/tb_imuldiv_unit > sim.log 2>&1 ||
  { echo "build or simulation error"; cat build.log; exit 1; }
cat sim.log
grep -q "^ALL CHECKS PASSED$" sim.log && echo "PASS" ||
  { echo "FAIL"; exit 1; }

/* verification/tb_imuldiv_unit.sv */
// table-driven testbench for the multiply/divide unit, inputs change on the falling edge
// expected results come from 64-bit reference arithmetic in this file

`timescale 1ns/1ps

module tb_imuldiv_unit import imuldiv_pkg::*; ();

  localparam int wait_limit = 200;

  logic              clk;
  logic              reset;
  logic              req_val;
  logic              req_rdy;
  imuldiv_fn_e       req_fn;
  logic [31:0]       req_a;
  logic [31:0]       req_b;
  logic              resp_val;
  logic              resp_rdy;
  logic [63:0]       resp_result;

  // stimulus table with one entry per operation
  imuldiv_fn_e fn_q[$];
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  int          stall_q[$];

  int          mismatches = 0;
  int          failures = 0;
  int          cur_row = -1;
  logic [31:0] lfsr;

  imuldiv_unit dut (
    .clk (clk), .reset (reset),
    .req_val (req_val), .req_rdy (req_rdy), .req_fn (req_fn),
    .req_a (req_a), .req_b (req_b),
    .resp_val (resp_val), .resp_rdy (resp_rdy), .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // galois lfsr stepped once per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // reference model where division packs {remainder, quotient}
  function automatic logic [63:0] expected_result(input imuldiv_fn_e fn,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    longint      sa;
    longint      sb;
    logic [31:0] q;
    logic [31:0] r;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    if (fn != fn_div && fn != fn_divu) begin
      // code 3 lands here too and behaves as a signed multiply
      return sa * sb;
    end
    if (b == 32'd0) begin
      return {a, 32'hffffffff};
    end
    if (fn == fn_div) begin
      // sv division truncates toward zero and % keeps the dividend sign
      q = 32'(sa / sb);
      r = 32'(sa % sb);
    end else begin
      q = a / b;
      r = a % b;
    end
    return {r, q};
  endfunction

  task automatic add_row(input imuldiv_fn_e fn, input logic [31:0] a,
                         input logic [31:0] b, input int stall);
    fn_q.push_back(fn);
    a_q.push_back(a);
    b_q.push_back(b);
    stall_q.push_back(stall);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s row %0d: got 0x%h expected 0x%h", name, cur_row, got, exp);
    end
  endtask

  task automatic wait_req_rdy(output bit ok);
    int n;
    n = 0;
    while (req_rdy !== 1'b1 && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    ok = (req_rdy === 1'b1);
    if (!ok) begin
      failures++;
      $display("timeout: req_rdy never went high before row %0d", cur_row);
    end
  endtask

  task automatic wait_resp_val(output bit ok);
    int n;
    n = 0;
    while (resp_val !== 1'b1 && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    ok = (resp_val === 1'b1);
    if (!ok) begin
      failures++;
      $display("timeout: no response arrived for row %0d", cur_row);
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    bit          ok;
    logic [63:0] held;
    imuldiv_fn_e r_fn;
    logic [31:0] r_a;
    logic [31:0] r_b;
    int          r_stall;
    reset = 1'b1;
    req_val = 1'b0;
    req_fn = fn_mul;
    req_a = '0;
    req_b = '0;
    resp_rdy = 1'b0;
    lfsr = 32'ha6031ef2;

    // directed corners with multiply first
    add_row(fn_mul, 32'd3, 32'd7, 0);
    add_row(fn_mul, -32'sd3, 32'd7, 2);
    add_row(fn_mul, -32'sd3, -32'sd7, 0);
    add_row(fn_mul, 32'd0, -32'sd5, 1);
    add_row(fn_mul, 32'h80000000, 32'h80000000, 0);
    add_row(fn_mul, 32'h80000000, 32'd1, 3);
    add_row(fn_mul, 32'h7fffffff, 32'h7fffffff, 0);
    add_row(imuldiv_fn_e'(2'd3), 32'd5, -32'sd6, 1);
    // signed divide over all four sign combinations and the overflow case
    add_row(fn_div, 32'd7, 32'd2, 0);
    add_row(fn_div, -32'sd7, 32'd2, 4);
    add_row(fn_div, 32'd7, -32'sd2, 0);
    add_row(fn_div, -32'sd7, -32'sd2, 1);
    add_row(fn_div, 32'h80000000, 32'hffffffff, 0);
    add_row(fn_div, 32'd5, 32'd0, 2);
    add_row(fn_div, -32'sd5, 32'd0, 0);
    // unsigned divide with the top bit set
    add_row(fn_divu, 32'hfffffff0, 32'd3, 0);
    add_row(fn_divu, 32'h80000000, 32'h7fffffff, 12);
    add_row(fn_divu, 32'd7, 32'hfffffffe, 0);
    add_row(fn_divu, 32'hfffffff0, 32'd0, 1);
    // random rows with the divisor shifted down so quotients are not all tiny
    for (int i = 0; i < 12; i++) begin
      r_fn = imuldiv_fn_e'(2'(take_bits(2)));
      r_a = take_bits(32);
      r_b = take_bits(32);
      r_b = r_b >> take_bits(5);
      r_stall = int'(take_bits(3));
      add_row(r_fn, r_a, r_b, r_stall);
    end

    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("req_rdy", 64'(req_rdy), 64'd1);
    check_value("resp_val", 64'(resp_val), 64'd0);

    for (int i = 0; i < fn_q.size(); i++) begin
      cur_row = i;
      wait_req_rdy(ok);
      if (!ok) break;
      req_val = 1'b1;
      req_fn = fn_q[i];
      req_a = a_q[i];
      req_b = b_q[i];
      @(negedge clk);
      req_val = 1'b0;
      check_value("req_rdy", 64'(req_rdy), 64'd0);
      wait_resp_val(ok);
      if (!ok) break;
      held = resp_result;
      check_value("resp_result", resp_result, expected_result(fn_q[i], a_q[i], b_q[i]));
      // response must sit still while resp_rdy is held low
      for (int s = 0; s < stall_q[i]; s++) begin
        @(negedge clk);
        check_value("resp_val", 64'(resp_val), 64'd1);
        check_value("resp_result", resp_result, held);
        check_value("req_rdy", 64'(req_rdy), 64'd0);
      end
      resp_rdy = 1'b1;
      @(negedge clk);
      resp_rdy = 1'b0;
      check_value("resp_val", 64'(resp_val), 64'd0);
      check_value("req_rdy", 64'(req_rdy), 64'd1);
    end

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
